//--- verilog/rv_exec_pkg.sv
package rv_exec_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  shamt_t;

  // Major opcodes and funct7 values handled by the decoder.
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_ALT     = 7'b0100000;
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operations
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [4:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    MUL,
    MULH,
    MULHSU,
    MULHU,
    DIV,
    DIVU,
    REM,
    REMU
  } alu_op_t;

  typedef struct packed {
    alu_op_t   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     imm;
    logic      use_imm;
    logic      is_lui;
    logic      writes_rd;
    logic      is_muldiv;
    logic      illegal;
  } decoded_t;

  typedef enum logic [1:0] {
    IDLE,
    MULTIPLY,
    DIVIDE,
    FINISH
  } md_state_t;

endpackage

//--- verilog/rv_decode.sv
`timescale 1ns/100ps

module rv_decode (
  input  rv_exec_pkg::xlen_t    instr,
  output rv_exec_pkg::decoded_t dec
);
  import rv_exec_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  shamt_t     shamt;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign shamt  = instr[24:20];

  always_comb begin
    dec           = '0;
    dec.op        = ADD;
    dec.rd        = instr[11:7];
    dec.rs1       = instr[19:15];
    dec.rs2       = instr[24:20];
    dec.writes_rd = 1'b1;

    case (opcode)
      OPC_OP: begin
        case (funct7)
          F7_BASE: begin
            case (funct3)
              3'b000:  dec.op = ADD;
              3'b001:  dec.op = SLL;
              3'b010:  dec.op = SLT;
              3'b011:  dec.op = SLTU;
              3'b100:  dec.op = XOR;
              3'b101:  dec.op = SRL;
              3'b110:  dec.op = OR;
              default: dec.op = AND;
            endcase
          end
          F7_ALT: begin
            if (funct3 == 3'b000) begin
              dec.op = SUB;
            end else if (funct3 == 3'b101) begin
              dec.op = SRA;
            end else begin
              dec.illegal = 1'b1;
            end
          end
          F7_MULDIV: begin
            dec.is_muldiv = 1'b1;
            case (funct3)
              3'b000:  dec.op = MUL;
              3'b001:  dec.op = MULH;
              3'b010:  dec.op = MULHSU;
              3'b011:  dec.op = MULHU;
              3'b100:  dec.op = DIV;
              3'b101:  dec.op = DIVU;
              3'b110:  dec.op = REM;
              default: dec.op = REMU;
            endcase
          end
          default: dec.illegal = 1'b1;
        endcase
      end

      OPC_OP_IMM: begin
        dec.use_imm = 1'b1;
        dec.imm     = {{20{instr[31]}}, instr[31:20]};
        case (funct3)
          3'b000: dec.op = ADD;
          3'b010: dec.op = SLT;
          3'b011: dec.op = SLTU;
          3'b100: dec.op = XOR;
          3'b110: dec.op = OR;
          3'b111: dec.op = AND;
          3'b001: begin
            dec.op      = SLL;
            dec.imm     = {27'b0, shamt};
            dec.illegal = (funct7 != F7_BASE);
          end
          default: begin
            // Right shifts pick logical or arithmetic from the upper immediate bits.
            dec.imm     = {27'b0, shamt};
            dec.op      = (funct7 == F7_ALT) ? SRA : SRL;
            dec.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          end
        endcase
      end

      OPC_LUI: begin
        dec.is_lui  = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm     = {instr[31:12], 12'b0};
      end

      default: dec.illegal = 1'b1;
    endcase

    if (dec.illegal) begin
      dec.writes_rd = 1'b0;
    end
  end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic                   clk,
  input  logic                   we,
  input  rv_exec_pkg::reg_addr_t waddr,
  input  rv_exec_pkg::xlen_t     wdata,
  input  rv_exec_pkg::reg_addr_t raddr1,
  input  rv_exec_pkg::reg_addr_t raddr2,
  output rv_exec_pkg::xlen_t     rdata1,
  output rv_exec_pkg::xlen_t     rdata2
);
  import rv_exec_pkg::*;

  // Only x1 to x31 are stored. x0 is a constant zero.
  xlen_t regs [1:31];

  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Reads see the contents before a write in the same cycle.
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu (
  input  rv_exec_pkg::alu_op_t op,
  input  rv_exec_pkg::xlen_t   a,
  input  rv_exec_pkg::xlen_t   b,
  output rv_exec_pkg::xlen_t   y
);
  import rv_exec_pkg::*;

  shamt_t shamt;
  logic   lt_signed;
  logic   lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ADD:     y = a + b;
      SUB:     y = a - b;
      SLL:     y = a << shamt;
      SLT:     y = {31'b0, lt_signed};
      SLTU:    y = {31'b0, lt_unsigned};
      XOR:     y = a ^ b;
      SRL:     y = a >> shamt;
      SRA:     y = $signed(a) >>> shamt;
      OR:      y = a | b;
      AND:     y = a & b;
      // Multiply and divide results come from mul_div.
      default: y = '0;
    endcase
  end

endmodule

//--- verilog/mul_div.sv
`timescale 1ns/100ps

module mul_div (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  rv_exec_pkg::alu_op_t op,
  input  rv_exec_pkg::xlen_t   a,
  input  rv_exec_pkg::xlen_t   b,
  output logic                 done,
  output rv_exec_pkg::xlen_t   result
);
  import rv_exec_pkg::*;

  md_state_t   state;
  alu_op_t     op_q;
  logic [6:0]  count;

  logic [63:0] mcand;
  logic [63:0] mplier;
  logic [63:0] prod;

  logic [64:0] quo;
  xlen_t       rem;
  xlen_t       dvsr;
  logic [32:0] rem_shift;
  logic [32:0] rem_diff;

  xlen_t       a_q;
  xlen_t       a_mag;
  xlen_t       b_mag;
  xlen_t       quo_fix;
  xlen_t       rem_fix;
  xlen_t       res_q;
  logic        signed_div;
  logic        is_mul_op;
  logic        a_neg;
  logic        q_neg;
  logic        div_zero;
  logic        div_ovf;

  assign is_mul_op  = op inside {MUL, MULH, MULHSU, MULHU};
  assign signed_div = op inside {DIV, REM};
  assign a_mag      = (signed_div && a[31]) ? -a : a;
  assign b_mag      = (signed_div && b[31]) ? -b : b;

  // Each restoring step brings in the next dividend bit and tries the divisor.
  assign rem_shift = {rem, quo[64]};
  assign rem_diff  = rem_shift - {1'b0, dvsr};

  assign quo_fix = q_neg ? -quo[31:0] : quo[31:0];
  assign rem_fix = a_neg ? -rem : rem;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= is_mul_op ? MULTIPLY : DIVIDE;
            if (op == MUL) begin
              count <= 7'd32;
            end else if (is_mul_op) begin
              count <= 7'd64;
            end else begin
              count <= 7'd65;
            end
          end
        end
        MULTIPLY: begin
          if (count != '0) begin
            count <= count - 7'd1;
          end else begin
            state <= IDLE;
          end
        end
        DIVIDE: begin
          if (count != '0) begin
            count <= count - 7'd1;
          end else begin
            state <= FINISH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        if (start) begin
          op_q <= op;
          a_q  <= a;
          prod <= '0;
          // High-word forms need the operands sign extended to 64 bits.
          mcand  <= (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
          mplier <= (op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
          quo      <= {33'b0, a_mag};
          rem      <= '0;
          dvsr     <= b_mag;
          a_neg    <= signed_div && a[31];
          q_neg    <= signed_div && (a[31] ^ b[31]);
          div_zero <= (b == '0);
          div_ovf  <= signed_div && (a == 32'h8000_0000) && (b == '1);
        end
      end
      MULTIPLY: begin
        if (count != '0) begin
          if (mplier[0]) begin
            prod <= prod + mcand;
          end
          mcand  <= mcand << 1;
          mplier <= mplier >> 1;
        end
      end
      DIVIDE: begin
        if (count != '0) begin
          if (!rem_diff[32]) begin
            rem <= rem_diff[31:0];
            quo <= {quo[63:0], 1'b1};
          end else begin
            rem <= rem_shift[31:0];
            quo <= {quo[63:0], 1'b0};
          end
        end else begin
          case (op_q)
            DIV:     res_q <= div_zero ? '1 : (div_ovf ? a_q : quo_fix);
            DIVU:    res_q <= div_zero ? '1 : quo[31:0];
            REM:     res_q <= div_zero ? a_q : (div_ovf ? '0 : rem_fix);
            default: res_q <= div_zero ? a_q : rem;
          endcase
        end
      end
      default: ;
    endcase
  end

  assign done   = ((state == MULTIPLY) && (count == '0)) || (state == FINISH);
  assign result = (state == FINISH) ? res_q :
                  (op_q == MUL)     ? prod[31:0] : prod[63:32];

  start_only_when_idle : assert property (@(posedge clk) disable iff (rst)
    start |-> (state == IDLE));

  done_single_pulse : assert property (@(posedge clk) disable iff (rst)
    done |=> !done);

endmodule

//--- verilog/exec_core.sv
`timescale 1ns/100ps

module exec_core #(
  parameter bit BYPASS_EN = 1'b1
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instr_valid,
  input  rv_exec_pkg::xlen_t     instr,
  output logic                   busy,
  output logic                   wb_valid,
  output rv_exec_pkg::reg_addr_t wb_rd,
  output rv_exec_pkg::xlen_t     wb_data,
  output logic                   illegal
);
  import rv_exec_pkg::*;

  typedef struct packed {
    decoded_t dec;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
  } issue_t;

  decoded_t  dec;
  issue_t    iss;
  logic      iss_valid;
  logic      accept;
  logic      wb_live;
  xlen_t     rdata1;
  xlen_t     rdata2;
  xlen_t     fwd1;
  xlen_t     fwd2;
  xlen_t     op_a;
  xlen_t     op_b;
  xlen_t     alu_y;
  xlen_t     md_result;
  logic      md_start;
  logic      md_done;
  logic      md_busy;
  reg_addr_t md_rd;

  rv_decode u_decode (.instr(instr), .dec(dec));

  reg_file u_regs (
    .clk    (clk),
    .we     (wb_valid),
    .waddr  (wb_rd),
    .wdata  (wb_data),
    .raddr1 (dec.rs1),
    .raddr2 (dec.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  assign accept  = instr_valid && !busy;
  assign wb_live = wb_valid && (wb_rd != '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Issue stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The register file still shows the old word during its own write cycle.
  always_ff @(posedge clk) begin
    if (accept) begin
      iss.dec     <= dec;
      iss.rs1_val <= (wb_live && (wb_rd == dec.rs1)) ? wb_data : rdata1;
      iss.rs2_val <= (wb_live && (wb_rd == dec.rs2)) ? wb_data : rdata2;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Execute stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign fwd1 = (BYPASS_EN && wb_live && (wb_rd == iss.dec.rs1)) ? wb_data : iss.rs1_val;
  assign fwd2 = (BYPASS_EN && wb_live && (wb_rd == iss.dec.rs2)) ? wb_data : iss.rs2_val;
  assign op_a = iss.dec.is_lui ? '0 : fwd1;
  assign op_b = iss.dec.use_imm ? iss.dec.imm : fwd2;

  alu u_alu (.op(iss.dec.op), .a(op_a), .b(op_b), .y(alu_y));

  assign md_start = iss_valid && iss.dec.is_muldiv;

  mul_div u_mul_div (
    .clk    (clk),
    .rst    (rst),
    .start  (md_start),
    .op     (iss.dec.op),
    .a      (op_a),
    .b      (op_b),
    .done   (md_done),
    .result (md_result)
  );

  // Busy covers the start cycle and every cycle up to the done pulse.
  assign busy = md_start || (md_busy && !md_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid <= 1'b0;
      wb_valid  <= 1'b0;
      illegal   <= 1'b0;
      md_busy   <= 1'b0;
    end else begin
      iss_valid <= accept;
      wb_valid  <= md_done || (iss_valid && iss.dec.writes_rd && !iss.dec.is_muldiv);
      illegal   <= iss_valid && iss.dec.illegal;
      if (md_start) begin
        md_busy <= 1'b1;
      end else if (md_done) begin
        md_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (md_start) begin
      md_rd <= iss.dec.rd;
    end
    if (md_done) begin
      wb_rd   <= md_rd;
      wb_data <= md_result;
    end else begin
      wb_rd   <= iss.dec.rd;
      wb_data <= alu_y;
    end
  end

  no_issue_while_busy : assert property (@(posedge clk) disable iff (rst)
    busy |-> !instr_valid);

endmodule

//--- bench/result_checker.sv
`timescale 1ns/100ps

module result_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  input  logic        busy,
  input  logic        wb_valid,
  input  logic [4:0]  wb_rd,
  input  logic [31:0] wb_data,
  input  logic        illegal,
  output int          errors,
  output int          checked,
  output int          outstanding
);

  logic [31:0] shadow [0:31];
  string       names_q [$];
  string       flight_name [$];
  logic [31:0] flight_word [$];
  int          flight_due [$];
  int          cycle;
  int          busy_run;
  int          last_run;

  task automatic expect_test(input string name);
    names_q.push_back(name);
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic bit is_legal(input logic [31:0] w);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = w[31:25];
    f3 = w[14:12];
    case (w[6:0])
      7'h37:   return 1'b1;
      7'h33:   return (f7 == 7'h00) || (f7 == 7'h01) ||
                      ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
      7'h13:   return (f3 == 3'd1) ? (f7 == 7'h00) :
                      ((f3 != 3'd5) || (f7 == 7'h00) || (f7 == 7'h20));
      default: return 1'b0;
    endcase
  endfunction

  // Cycles from the strobe to the write-back.
  function automatic int wb_delay(input logic [31:0] w);
    if ((w[6:0] != 7'h33) || (w[31:25] != 7'h01)) return 2;
    if (w[14:12] == 3'd0) return 35;
    return (w[14:12] < 3'd4) ? 67 : 69;
  endfunction

  function automatic logic [31:0] muldiv_ref(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] prod;
    logic        ovf;
    ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    case (f3)
      3'd0: prod = {32'b0, a} * {32'b0, b};
      3'd1: prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      3'd2: prod = {{32{a[31]}}, a} * {32'b0, b};
      3'd3: prod = {32'b0, a} * {32'b0, b};
      3'd4: return (b == '0) ? 32'hFFFF_FFFF :
                   (ovf ? a : $unsigned($signed(a) / $signed(b)));
      3'd5: return (b == '0) ? 32'hFFFF_FFFF : a / b;
      3'd6: return (b == '0) ? a : (ovf ? 32'h0 : $unsigned($signed(a) % $signed(b)));
      default: return (b == '0) ? a : a % b;
    endcase
    return (f3 == 3'd0) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic logic [31:0] reference(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic        alt;
    a   = shadow[w[19:15]];
    b   = (w[6:0] == 7'h13) ? {{20{w[31]}}, w[31:20]} : shadow[w[24:20]];
    sh  = b[4:0];
    alt = (w[31:25] == 7'h20);
    if (w[6:0] == 7'h37) return {w[31:12], 12'h000};
    if ((w[6:0] == 7'h33) && (w[31:25] == 7'h01)) return muldiv_ref(w[14:12], a, b);
    case (w[14:12])
      3'd0:    return ((w[6:0] == 7'h33) && alt) ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    logic [31:0] w;
    logic [31:0] want;
    string       name;
    int          due;
    if (rst) begin
      for (int i = 0; i < 32; i++)
        shadow[i] = '0;
      cycle       = 0;
      busy_run    = 0;
      last_run    = 0;
      errors      = 0;
      checked     = 0;
      outstanding = 0;
    end else begin
      cycle++;
      if (busy) begin
        busy_run++;
      end else if (busy_run != 0) begin
        last_run = busy_run;
        busy_run = 0;
      end
      if (instr_valid) begin
        if (names_q.size() == 0) begin
          flag_error($sformatf("Strobe at cycle %0d has no test entry", cycle));
        end else begin
          flight_name.push_back(names_q.pop_front());
          flight_word.push_back(instr);
          flight_due.push_back(cycle + wb_delay(instr));
        end
      end
      if (wb_valid || illegal) begin
        if (flight_due.size() == 0) begin
          flag_error($sformatf("Unexpected write-back or illegal pulse at cycle %0d", cycle));
        end else begin
          name = flight_name.pop_front();
          w    = flight_word.pop_front();
          due  = flight_due.pop_front();
          if (due != cycle)
            flag_error($sformatf("Test %s answered at cycle %0d instead of %0d",
                                 name, cycle, due));
          if (!is_legal(w)) begin
            if (wb_valid || !illegal)
              flag_error($sformatf("Test %s should raise only the illegal pulse", name));
          end else if (!wb_valid) begin
            flag_error($sformatf("Test %s raised illegal on a supported encoding", name));
          end else begin
            want = reference(w);
            checked++;
            if (wb_rd != w[11:7])
              flag_error($sformatf("MISMATCH %s rd: expected %0d, actual %0d",
                                   name, w[11:7], wb_rd));
            if (wb_data !== want)
              flag_error($sformatf("MISMATCH %s: expected %h, actual %h", name, want, wb_data));
            if ((wb_delay(w) > 2) && (last_run != wb_delay(w) - 2))
              flag_error($sformatf("MISMATCH %s busy cycles: expected %0d, actual %0d",
                                   name, wb_delay(w) - 2, last_run));
            if (w[11:7] != 5'd0)
              shadow[w[11:7]] = want;
          end
        end
      end else if ((flight_due.size() != 0) && (flight_due[0] <= cycle)) begin
        flag_error($sformatf("Test %s gave no write-back or illegal pulse by cycle %0d",
                             flight_name[0], cycle));
        void'(flight_name.pop_front());
        void'(flight_word.pop_front());
        void'(flight_due.pop_front());
      end
      outstanding = names_q.size() + flight_due.size();
    end
  end

endmodule

//--- bench/tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic        busy;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        illegal;
  int          errors;
  int          checked;
  int          outstanding;

  string       test_name [$];
  logic [31:0] test_word [$];
  bit          test_wait [$];
  logic [31:0] lfsr;
  int          limit;
  string       md_mnem [0:7] = '{"mul", "mulh", "mulhsu", "mulhu",
                                 "div", "divu", "rem", "remu"};

  exec_core #(.BYPASS_EN(1'b1)) UUT (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .busy        (busy),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .illegal     (illegal)
  );

  result_checker u_check (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .busy        (busy),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .illegal     (illegal),
    .errors      (errors),
    .checked     (checked),
    .outstanding (outstanding)
  );

  always #4 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encoders and random values
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] upper, input logic [4:0] rd);
    return {upper, rd, 7'h37};
  endfunction

  // Galois form, shifting right.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic draw_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic add_test(input string name, input logic [31:0] word, input bit wait_busy);
    test_name.push_back(name);
    test_word.push_back(word);
    test_wait.push_back(wait_busy);
  endtask

  // ADDI sign extends its immediate, so the upper part absorbs bit 11.
  task automatic load_constant(input logic [4:0] rd, input logic [31:0] v);
    add_test($sformatf("lui x%0d", rd), lui_word(v[31:12] + {19'b0, v[11]}, rd), 1'b0);
    add_test($sformatf("addi x%0d", rd), i_type(v[11:0], rd, 3'd0, rd), 1'b0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic build_table();
    logic [31:0] v;
    logic [4:0]  pa [0:4];
    logic [4:0]  pb [0:4];
    for (int r = 1; r <= 4; r++) begin
      draw_word(v);
      load_constant(5'(r), v);
    end
    add_test("add x6", r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd6), 1'b0);
    add_test("sub x7", r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd7), 1'b0);
    add_test("xor x8", r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd8), 1'b0);
    add_test("or x9", r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd9), 1'b0);
    add_test("and x10", r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd10), 1'b0);
    // Each of these reads the result of the one before it.
    add_test("chain add", r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd11), 1'b0);
    add_test("chain add dep", r_type(7'h00, 5'd3, 5'd11, 3'd0, 5'd11), 1'b0);
    add_test("chain sub dep", r_type(7'h20, 5'd4, 5'd11, 3'd0, 5'd11), 1'b0);
    add_test("chain xor dep", r_type(7'h00, 5'd1, 5'd11, 3'd4, 5'd12), 1'b0);
    add_test("addi x13 -5", i_type(12'hFFB, 5'd0, 3'd0, 5'd13), 1'b0);
    add_test("addi x14 31", i_type(12'h01F, 5'd0, 3'd0, 5'd14), 1'b0);
    add_test("sll by 31", r_type(7'h00, 5'd14, 5'd13, 3'd1, 5'd16), 1'b0);
    add_test("srl by 31", r_type(7'h00, 5'd14, 5'd13, 3'd5, 5'd16), 1'b0);
    add_test("sra by 31", r_type(7'h20, 5'd14, 5'd13, 3'd5, 5'd16), 1'b0);
    add_test("sra by 0", r_type(7'h20, 5'd0, 5'd13, 3'd5, 5'd16), 1'b0);
    add_test("slli 31", i_type(12'h01F, 5'd13, 3'd1, 5'd17), 1'b0);
    add_test("srli 0", i_type(12'h000, 5'd13, 3'd5, 5'd17), 1'b0);
    add_test("srli 31", i_type(12'h01F, 5'd13, 3'd5, 5'd17), 1'b0);
    add_test("srai 31", i_type(12'h41F, 5'd13, 3'd5, 5'd17), 1'b0);
    add_test("slt neg", r_type(7'h00, 5'd1, 5'd13, 3'd2, 5'd18), 1'b0);
    add_test("sltu neg", r_type(7'h00, 5'd1, 5'd13, 3'd3, 5'd18), 1'b0);
    add_test("slti -1", i_type(12'hFFF, 5'd13, 3'd2, 5'd18), 1'b0);
    add_test("sltiu -1", i_type(12'hFFF, 5'd13, 3'd3, 5'd18), 1'b0);
    add_test("lui x19 min", lui_word(20'h80000, 5'd19), 1'b0);
    add_test("addi x20 -1", i_type(12'hFFF, 5'd0, 3'd0, 5'd20), 1'b0);
    load_constant(5'd21, 32'h7FFF_FFFF);
    // The pairs are random, overflow, negative by maximum and two zero divisors.
    pa = '{5'd1, 5'd19, 5'd13, 5'd1, 5'd13};
    pb = '{5'd2, 5'd20, 5'd21, 5'd0, 5'd0};
    for (int f = 0; f < 8; f++) begin
      for (int p = 0; p < ((f < 4) ? 3 : 5); p++) begin
        add_test($sformatf("%s x%0d,x%0d", md_mnem[f], pa[p], pb[p]),
                 r_type(7'h01, pb[p], pa[p], 3'(f), 5'd23), 1'b1);
      end
    end
    add_test("add after muldiv", r_type(7'h00, 5'd1, 5'd23, 3'd0, 5'd24), 1'b0);
    add_test("system opcode", 32'h0000_0073, 1'b0);
    add_test("bad funct7", r_type(7'h20, 5'd2, 5'd1, 3'd1, 5'd3), 1'b0);
    add_test("add to x0", r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0), 1'b0);
    add_test("addi to x0", i_type(12'h005, 5'd0, 3'd0, 5'd0), 1'b0);
    add_test("x0 reads zero", r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd25), 1'b0);
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr        = 32'd56;
    limit       = 0;
    build_table();
    limit = test_word.size() * 80 + 200;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    foreach (test_word[i]) begin
      @(posedge clk);
      u_check.expect_test(test_name[i]);
      instr_valid <= 1'b1;
      instr       <= test_word[i];
      if (test_wait[i]) begin
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        while (busy) @(negedge clk);
      end
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    while (outstanding != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    $display("Checked %0d write-backs, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    wait (limit != 0);
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles with %0d results still outstanding",
             limit, outstanding);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- sources.f
verilog/rv_exec_pkg.sv
verilog/rv_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/mul_div.sv
verilog/exec_core.sv
bench/result_checker.sv
bench/tb_exec_core.sv

//--- Makefile
TOP = tb_exec_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
